// ==== src/fifo_pkg.sv ====
package fifo_pkg;

   // port widths, bytes in and words out
   localparam int W_DATA_W = 8;
   localparam int R_DATA_W = 32;
   localparam int N_LANES  = R_DATA_W / W_DATA_W;

   // byte addressing over the whole FIFO
   localparam int ADDR_W      = 6;
   localparam int LANE_W      = $clog2(N_LANES);
   localparam int BANK_ADDR_W = ADDR_W - LANE_W;
   localparam int BANK_DEPTH  = 1 << BANK_ADDR_W;
   localparam int FIFO_BYTES  = 1 << ADDR_W;

   // level steps, counted in bytes
   localparam int W_INCR = 1;
   localparam int R_INCR = N_LANES;

   typedef logic [W_DATA_W-1:0]    w_data_t;
   typedef logic [R_DATA_W-1:0]    r_data_t;
   typedef logic [ADDR_W-1:0]      w_addr_t;
   typedef logic [BANK_ADDR_W-1:0] r_addr_t;
   typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

   // one extra bit so that a full FIFO is distinct from an empty one
   typedef logic [ADDR_W:0] level_t;

   // write request, one enable bit per lane
   typedef struct packed {
      logic [N_LANES-1:0] we;
      bank_addr_t         addr;
      w_data_t            data;
   } mem_wr_t;

   // read request, shared by all lanes
   typedef struct packed {
      logic       en;
      bank_addr_t addr;
   } mem_rd_t;

   // lane 0 sits in the low byte
   typedef logic [N_LANES-1:0][W_DATA_W-1:0] mem_rdata_t;

endpackage

// ==== src/ram_2p_bank.sv ====
`timescale 1ns/1ps

module ram_2p_bank (
   input  logic                  clk_i,
   input  logic                  w_en_i,
   input  fifo_pkg::bank_addr_t  w_addr_i,
   input  fifo_pkg::w_data_t     w_data_i,
   input  logic                  r_en_i,
   input  fifo_pkg::bank_addr_t  r_addr_i,
   output fifo_pkg::w_data_t     r_data_o
);

   fifo_pkg::w_data_t mem [fifo_pkg::BANK_DEPTH];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // registered read, output holds between reads
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

// ==== src/ram_2p_asym.sv ====
`timescale 1ns/1ps

module ram_2p_asym (
   input  logic                  clk_i,

   // byte write side
   input  logic                  w_en_i,
   input  fifo_pkg::w_addr_t     w_addr_i,
   input  fifo_pkg::w_data_t     w_data_i,

   // word read side
   input  logic                  r_en_i,
   input  fifo_pkg::r_addr_t     r_addr_i,
   output fifo_pkg::r_data_t     r_data_o,

   // bank requests and returned lanes
   output fifo_pkg::mem_wr_t     mem_wr_o,
   output fifo_pkg::mem_rd_t     mem_rd_o,
   input  fifo_pkg::mem_rdata_t  mem_rdata_i
);

   logic [fifo_pkg::LANE_W-1:0]  w_lane;
   fifo_pkg::bank_addr_t         w_bank_addr;
   logic [fifo_pkg::N_LANES-1:0] w_lane_en;

   fifo_pkg::r_data_t            rd_word;

   // low bits pick the lane, the rest is the row inside each bank
   assign w_lane      = w_addr_i[fifo_pkg::LANE_W-1:0];
   assign w_bank_addr = w_addr_i[fifo_pkg::ADDR_W-1:fifo_pkg::LANE_W];

   always_comb begin
      w_lane_en = '0;
      if (w_en_i) begin
         w_lane_en[w_lane] = 1'b1;
      end
   end

   assign mem_wr_o.we   = w_lane_en;
   assign mem_wr_o.addr = w_bank_addr;
   assign mem_wr_o.data = w_data_i;

   // all lanes read the same row together
   assign mem_rd_o.en   = r_en_i;
   assign mem_rd_o.addr = r_addr_i;

   // lane k holds byte k of the word, so the flat view is stream order
   assign rd_word = fifo_pkg::r_data_t'(mem_rdata_i);

   // banks hold their output between reads
   assign r_data_o = rd_word;

endmodule

// ==== src/fifo_sync.sv ====
`timescale 1ns/1ps

module fifo_sync (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  ce_i,
   input  logic                  clr_i,

   // write port
   input  logic                  w_en_i,
   input  fifo_pkg::w_data_t     w_data_i,
   output logic                  w_full_o,

   // read port
   input  logic                  r_en_i,
   output fifo_pkg::r_data_t     r_data_o,
   output logic                  r_empty_o,

   // occupancy in bytes
   output fifo_pkg::level_t      level_o,

   // external memory
   output fifo_pkg::mem_wr_t     mem_wr_o,
   output fifo_pkg::mem_rd_t     mem_rd_o,
   input  fifo_pkg::mem_rdata_t  mem_rdata_i
);

   logic                 w_en_int;
   logic                 r_en_int;

   fifo_pkg::w_addr_t    w_addr_q;
   fifo_pkg::r_addr_t    r_addr_q;

   fifo_pkg::level_t     level_q;
   fifo_pkg::level_t     level_nxt;

   logic                 r_empty_q;
   logic                 r_empty_nxt;
   logic                 w_full_q;
   logic                 w_full_nxt;

   // accepted strobes, nothing moves on a frozen or clearing edge
   assign w_en_int = w_en_i & ~w_full_q & ce_i & ~clr_i;
   assign r_en_int = r_en_i & ~r_empty_q & ce_i & ~clr_i;

   // byte write pointer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         w_addr_q <= '0;
      end else if (ce_i) begin
         if (clr_i) begin
            w_addr_q <= '0;
         end else if (w_en_int) begin
            w_addr_q <= w_addr_q + fifo_pkg::w_addr_t'(1);
         end
      end
   end

   // word read pointer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r_addr_q <= '0;
      end else if (ce_i) begin
         if (clr_i) begin
            r_addr_q <= '0;
         end else if (r_en_int) begin
            r_addr_q <= r_addr_q + fifo_pkg::r_addr_t'(1);
         end
      end
   end

   // +1 per byte written, -4 per word read, both in one cycle is fine
   always_comb begin
      level_nxt = level_q;
      if (clr_i) begin
         level_nxt = '0;
      end else begin
         if (w_en_int) begin
            level_nxt = level_nxt + fifo_pkg::level_t'(fifo_pkg::W_INCR);
         end
         if (r_en_int) begin
            level_nxt = level_nxt - fifo_pkg::level_t'(fifo_pkg::R_INCR);
         end
      end
   end

   // flags look at the next level so they line up with level_o
   assign r_empty_nxt = level_nxt < fifo_pkg::level_t'(fifo_pkg::R_INCR);
   assign w_full_nxt  = level_nxt >
                        fifo_pkg::level_t'(fifo_pkg::FIFO_BYTES - fifo_pkg::W_INCR);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         level_q   <= '0;
         r_empty_q <= 1'b1;
         w_full_q  <= 1'b0;
      end else if (ce_i) begin
         level_q   <= level_nxt;
         r_empty_q <= r_empty_nxt;
         w_full_q  <= w_full_nxt;
      end
   end

   assign level_o   = level_q;
   assign r_empty_o = r_empty_q;
   assign w_full_o  = w_full_q;

   ram_2p_asym ram_2p_asym_i (
      .clk_i       (clk_i),
      .w_en_i      (w_en_int),
      .w_addr_i    (w_addr_q),
      .w_data_i    (w_data_i),
      .r_en_i      (r_en_int),
      .r_addr_i    (r_addr_q),
      .r_data_o    (r_data_o),
      .mem_wr_o    (mem_wr_o),
      .mem_rd_o    (mem_rd_o),
      .mem_rdata_i (mem_rdata_i)
   );

endmodule

// ==== src/fifo_subsys.sv ====
`timescale 1ns/1ps

module fifo_subsys (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               ce_i,
   input  logic               clr_i,

   input  logic               w_en_i,
   input  fifo_pkg::w_data_t  w_data_i,
   output logic               w_full_o,

   input  logic               r_en_i,
   output fifo_pkg::r_data_t  r_data_o,
   output logic               r_empty_o,

   output fifo_pkg::level_t   level_o
);

   fifo_pkg::mem_wr_t     mem_wr;
   fifo_pkg::mem_rd_t     mem_rd;
   fifo_pkg::mem_rdata_t  mem_rdata;

   fifo_sync fifo_sync_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .ce_i        (ce_i),
      .clr_i       (clr_i),
      .w_en_i      (w_en_i),
      .w_data_i    (w_data_i),
      .w_full_o    (w_full_o),
      .r_en_i      (r_en_i),
      .r_data_o    (r_data_o),
      .r_empty_o   (r_empty_o),
      .level_o     (level_o),
      .mem_wr_o    (mem_wr),
      .mem_rd_o    (mem_rd),
      .mem_rdata_i (mem_rdata)
   );

   // one byte bank per lane
   for (genvar g = 0; g < fifo_pkg::N_LANES; g++) begin : g_bank
      ram_2p_bank ram_2p_bank_i (
         .clk_i    (clk_i),
         .w_en_i   (mem_wr.we[g]),
         .w_addr_i (mem_wr.addr),
         .w_data_i (mem_wr.data),
         .r_en_i   (mem_rd.en),
         .r_addr_i (mem_rd.addr),
         .r_data_o (mem_rdata[g])
      );
   end

endmodule

// ==== dv/fifo_tb.sv ====
`timescale 1ns/1ps

module fifo_tb;

   // cycle budget per test, used by the timeout
   localparam int T_RESET = 6;
   localparam int T_ORDER = 20;
   localparam int T_FULL  = 84;
   localparam int T_EMPTY = 8;
   localparam int T_MIXED = 316;
   localparam int T_CLEAR = 24;
   localparam int T_CE    = 28;
   localparam int CYCLE_LIMIT = T_RESET + T_ORDER + T_FULL + T_EMPTY + T_MIXED +
                                T_CLEAR + T_CE + 200;

   logic                 clk_i;
   logic                 rst_n_i;
   logic                 ce_i;
   logic                 clr_i;
   logic                 w_en_i;
   fifo_pkg::w_data_t    w_data_i;
   logic                 w_full_o;
   logic                 r_en_i;
   fifo_pkg::r_data_t    r_data_o;
   logic                 r_empty_o;
   fifo_pkg::level_t     level_o;

   // reference model, bytes in stream order
   fifo_pkg::w_data_t    byte_q[$];
   fifo_pkg::r_data_t    last_word;
   logic                 have_word;

   logic [15:0]          lfsr_q;
   int                   cycle_cnt;
   int                   err_count;
   int                   test_err_base;
   int                   tests_passed;
   int                   tests_failed;

   fifo_subsys fifo_subsys_i (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .ce_i      (ce_i),
      .clr_i     (clr_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_full_o  (w_full_o),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_empty_o (r_empty_o),
      .level_o   (level_o)
   );

   initial begin
      clk_i = 1'b0;
   end

   always begin
      #50 clk_i = ~clk_i;
   end

   initial begin
      cycle_cnt = 0;
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Something failed");
         $finish;
      end
   end

   // galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end
      return s >> 1;
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Error: %s is 0x%0h, expected 0x%0h at cycle %0d",
                  name, actual, expected, cycle_cnt);
         err_count++;
      end
   endtask

   // drive one cycle, let the model follow the same rules, compare after the edge
   task automatic apply_cycle(input logic ce, input logic clr, input logic wen,
                              input logic ren, input fifo_pkg::w_data_t wd);
      logic              wr_ok;
      logic              rd_ok;
      fifo_pkg::r_data_t word;
      ce_i     = ce;
      clr_i    = clr;
      w_en_i   = wen;
      r_en_i   = ren;
      w_data_i = wd;
      wr_ok = ce && !clr && wen && !(byte_q.size() > 63);
      rd_ok = ce && !clr && ren && !(byte_q.size() < 4);
      @(posedge clk_i);
      @(negedge clk_i);
      if (ce && clr) begin
         byte_q.delete();
      end
      if (rd_ok) begin
         // first byte of the word goes to the low lane
         for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = byte_q.pop_front();
         end
         last_word = word;
         have_word = 1'b1;
      end
      if (wr_ok) begin
         byte_q.push_back(wd);
      end
      check("level_o", 32'(level_o), byte_q.size());
      check("r_empty_o", 32'(r_empty_o), 32'(byte_q.size() < 4));
      check("w_full_o", 32'(w_full_o), 32'(byte_q.size() > 63));
      if (have_word) begin
         check("r_data_o", r_data_o, last_word);
      end
   endtask

   task automatic write_byte();
      apply_cycle(1'b1, 1'b0, 1'b1, 1'b0, fifo_pkg::w_data_t'(rand_bits(8)));
   endtask

   task automatic read_word();
      apply_cycle(1'b1, 1'b0, 1'b0, 1'b1, '0);
   endtask

   task automatic start_test();
      test_err_base = err_count;
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = err_count - test_err_base;
      if (errs == 0) begin
         tests_passed++;
         $display("test %-8s passed", name);
      end else begin
         tests_failed++;
         $display("test %-8s FAILED with %0d mismatches", name, errs);
      end
   endtask

   initial begin
      rst_n_i   = 1'b0;
      ce_i      = 1'b0;
      clr_i     = 1'b0;
      // strobes held high while frozen, so no request may reach the banks
      w_en_i    = 1'b1;
      r_en_i    = 1'b1;
      w_data_i  = '0;
      lfsr_q    = 16'd37;
      have_word = 1'b0;
      last_word = '0;
      err_count     = 0;
      test_err_base = 0;
      tests_passed  = 0;
      tests_failed  = 0;

      repeat (5) @(negedge clk_i);
      rst_n_i = 1'b1;

      start_test();
      check("level_o", 32'(level_o), 32'd0);
      check("r_empty_o", 32'(r_empty_o), 32'd1);
      check("w_full_o", 32'(w_full_o), 32'd0);
      check("mem_wr.we", 32'(fifo_subsys_i.mem_wr.we), 32'd0);
      check("mem_rd.en", 32'(fifo_subsys_i.mem_rd.en), 32'd0);
      apply_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0);
      end_test("reset");

      // 16 bytes in, 4 words out
      start_test();
      repeat (16) write_byte();
      repeat (4) read_word();
      end_test("ordering");

      // fill, push past full, then drain
      start_test();
      repeat (64) write_byte();
      repeat (4) write_byte();
      repeat (16) read_word();
      end_test("full");

      start_test();
      read_word();
      for (int n = 1; n <= 3; n++) begin
         write_byte();
         read_word();
      end
      end_test("empty");

      // first half fills up, second half drains
      start_test();
      for (int c = 0; c < 300; c++) begin
         if (c < 150) begin
            apply_cycle(1'b1, 1'b0, rand_bits(3) != 0, rand_bits(3) == 0,
                        fifo_pkg::w_data_t'(rand_bits(8)));
         end else begin
            apply_cycle(1'b1, 1'b0, rand_bits(1) != 0, rand_bits(2) == 0,
                        fifo_pkg::w_data_t'(rand_bits(8)));
         end
      end
      while (byte_q.size() >= 4) begin
         read_word();
      end
      end_test("mixed");

      // clear wins over a write and a read in the same cycle
      start_test();
      repeat (10) write_byte();
      apply_cycle(1'b1, 1'b1, 1'b1, 1'b1, fifo_pkg::w_data_t'(rand_bits(8)));
      apply_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0);
      repeat (8) write_byte();
      repeat (2) read_word();
      end_test("clear");

      // frozen cycles with random strobes, nothing may move
      start_test();
      repeat (8) write_byte();
      read_word();
      repeat (12) begin
         apply_cycle(1'b0, rand_bits(1) != 0, rand_bits(1) != 0, rand_bits(1) != 0,
                     fifo_pkg::w_data_t'(rand_bits(8)));
      end
      repeat (4) write_byte();
      repeat (2) read_word();
      end_test("ce");

      $display("tests passed %0d, tests failed %0d, mismatches %0d",
               tests_passed, tests_failed, err_count);
      if (err_count == 0 && tests_failed == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
src/fifo_pkg.sv
src/ram_2p_bank.sv
src/ram_2p_asym.sv
src/fifo_sync.sv
src/fifo_subsys.sv
dv/fifo_tb.sv

// ==== Makefile ====
# Verilator simulation of the byte-in, word-out FIFO

VERILATOR ?= verilator
TOP       ?= fifo_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
